//--- design/flash_addr_decode.sv
/*
 * Decode stage: strobe qualification, flash or page window select,
 * byte-select classification
 */

`timescale 1ns/1ns

module flash_addr_decode
  import flash_bus_pkg::*;
(
  input  logic    wb_clk_i,
  input  logic    rst_n_i,
  input  wb_req_t req_i,
  output dec_t    dec_o
);

  // Active bus cycle
  logic      op;
  // Upper half of the address map
  logic      page_win;
  acc_kind_t kind;

  assign op       = req_i.cyc & req_i.stb;
  // Bit 16 of the bus address
  assign page_win = req_i.adr[15];

  // Byte selects to access width
  always_comb begin
    case (req_i.sel)
      2'b01:   kind = ACC_LO;
      2'b10:   kind = ACC_HI;
      2'b11:   kind = ACC_WORD;
      default: kind = ACC_NONE;
    endcase
  end

  // Window targets
  assign dec_o.flash_op = op & ~page_win;
  assign dec_o.page_op  = op & page_win;
  assign dec_o.we       = req_i.we;
  assign dec_o.kind     = kind;
  // Word offset inside the window
  assign dec_o.word_adr = req_i.adr[14:0];

  // Master never runs a cycle with no byte lane enabled
  a_sel_nonzero : assert property (
    @(posedge wb_clk_i) disable iff (!rst_n_i)
    (req_i.cyc && req_i.stb) |-> (req_i.sel != 2'b00)
  ) else $error("bus cycle with empty byte select");

endmodule

//--- design/flash_bus_pkg.sv
/*
 * Wishbone request and response structs for the boot-flash slave,
 * the access-width enumeration and the decoded request struct
 */

package flash_bus_pkg;

  // Classic Wishbone request as seen by the slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  sel;
    // Word address, bus bits 16 to 1
    logic [15:0] adr;
    logic [15:0] dat;
  } wb_req_t;

  // Slave response back to the master
  typedef struct packed {
    logic        ack;
    logic [15:0] dat;
  } wb_rsp_t;

  // Width of an access, from the byte selects
  typedef enum logic [1:0] {
    ACC_NONE = 2'b00,
    ACC_LO   = 2'b01,
    ACC_HI   = 2'b10,
    ACC_WORD = 2'b11
  } acc_kind_t;

  // Decode result shared by the later stages
  typedef struct packed {
    logic        flash_op;
    logic        page_op;
    logic        we;
    acc_kind_t   kind;
    logic [14:0] word_adr;
  } dec_t;

endpackage

//--- design/flash_byte_seq.sv
/*
 * Execute stage: one or two byte fetches per bus cycle,
 * flash address and pad control
 */

`timescale 1ns/1ns

module flash_byte_seq
  import flash_bus_pkg::*;
  import flash_pad_pkg::*;
#(
  parameter int FLASH_ADDR_W = 22
) (
  input  logic                              wb_clk_i,
  input  logic                              rst_n_i,
  input  dec_t                              dec_i,
  input  logic [FLASH_ADDR_W-WIN_ADR_W-1:0] page_i,
  output flash_pad_t                        pad_o,
  output logic                              step_o,
  output logic                              lo_take_o
);

  logic                    flash_rd;
  logic                    word_rd;
  // Second fetch of a word read
  logic                    step;
  logic                    byte_bit;
  logic [FLASH_ADDR_W-1:0] flash_addr;

  // Writes to the flash window never reach the pads
  assign flash_rd = dec_i.flash_op & ~dec_i.we;
  assign word_rd  = flash_rd & (dec_i.kind == ACC_WORD);

  // Step toggles through a word read, so back-to-back
  // word reads each take two cycles
  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      step <= 1'b0;
    end else begin
      step <= word_rd & ~step;
    end
  end

  // Odd byte for a high-byte read or the second fetch
  assign byte_bit = (dec_i.kind == ACC_HI) |
                    ((dec_i.kind == ACC_WORD) & step);

  // Page, word offset, byte lane
  assign flash_addr = {page_i, dec_i.word_adr, byte_bit};

  assign pad_o.addr  = flash_addr;
  assign pad_o.oe_n  = ~flash_rd;
  // Read-only part: no program, no device reset
  assign pad_o.we_n  = 1'b1;
  assign pad_o.rst_n = 1'b1;

  assign step_o    = step;
  // Low byte of a word read is on the pads now
  assign lo_take_o = word_rd & ~step;

  // Word read never stalls more than one cycle
  a_step_single : assert property (
    @(posedge wb_clk_i) disable iff (!rst_n_i)
    step |=> !step
  ) else $error("step flag high two cycles in a row");

endmodule

//--- design/flash_pad_pkg.sv
/*
 * Flash pad struct and the address-width constants
 */

package flash_pad_pkg;

  // Byte-wide NOR data bus
  localparam int FLASH_DATA_W = 8;

  // Byte-address bits inside the 64 KB bus window
  localparam int WIN_ADR_W = 16;

  // Pad outputs toward the flash
  // Address width matches the default 4 MB part
  typedef struct packed {
    logic [21:0] addr;
    // Output enable, low during a read
    logic        oe_n;
    // Write enable, held inactive
    logic        we_n;
    // Device reset, held inactive
    logic        rst_n;
  } flash_pad_t;

endpackage

//--- design/flash_page_reg.sv
/*
 * Writable flash page register in the upper bus window
 */

`timescale 1ns/1ns

module flash_page_reg
  import flash_bus_pkg::*;
  import flash_pad_pkg::*;
#(
  parameter int FLASH_ADDR_W = 22
) (
  input  logic                                 wb_clk_i,
  input  logic                                 rst_n_i,
  input  dec_t                                 dec_i,
  input  logic [15:0]                          wdat_i,
  output logic [FLASH_ADDR_W-WIN_ADR_W-1:0]    page_o,
  output logic                                 ack_o,
  output logic [15:0]                          rdat_o
);

  // Page bits above the bus window
  localparam int PAGE_W = FLASH_ADDR_W - WIN_ADR_W;

  logic [PAGE_W-1:0] page;
  logic              page_wr;

  // Write hits the low byte lane
  assign page_wr = dec_i.page_op & dec_i.we &
                   ((dec_i.kind == ACC_LO) | (dec_i.kind == ACC_WORD));

  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      page <= '0;
    end else if (page_wr) begin
      page <= wdat_i[PAGE_W-1:0];
    end
  end

  assign page_o = page;

  // No wait states in the page window
  assign ack_o  = dec_i.page_op;

  // Read back zero-extended
  assign rdat_o = {{(16-PAGE_W){1'b0}}, page};

  // Page only moves on a page write
  a_page_stable : assert property (
    @(posedge wb_clk_i) disable iff (!rst_n_i)
    !page_wr |=> $stable(page)
  ) else $error("page register changed without a write");

endmodule

//--- design/flash_read_merge.sv
/*
 * Result stage: low-byte capture, read data assembly, acknowledge
 */

`timescale 1ns/1ns

module flash_read_merge
  import flash_bus_pkg::*;
  import flash_pad_pkg::*;
(
  input  logic                    wb_clk_i,
  input  logic                    rst_n_i,
  input  dec_t                    dec_i,
  input  logic                    step_i,
  input  logic                    lo_take_i,
  input  logic [FLASH_DATA_W-1:0] flash_dat_i,
  input  logic                    page_ack_i,
  input  logic [15:0]             page_dat_i,
  output wb_rsp_t                 rsp_o
);

  // Captured low byte of a word read
  logic [FLASH_DATA_W-1:0] lo_byte;
  logic                    hi_sel;
  logic                    flash_ack;

  // Holds only across the two cycles of a word read
  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lo_byte <= '0;
    end else if (lo_take_i) begin
      lo_byte <= flash_dat_i;
    end else begin
      lo_byte <= '0;
    end
  end

  // High lane enabled, word or high byte
  assign hi_sel = (dec_i.kind == ACC_HI) | (dec_i.kind == ACC_WORD);

  // Word read waits for the second fetch
  assign flash_ack = dec_i.flash_op &
                     (dec_i.we | (dec_i.kind != ACC_WORD) | step_i);

  always_comb begin
    if (dec_i.page_op) begin
      rsp_o.dat = page_dat_i;
    end else if (hi_sel) begin
      rsp_o.dat = {flash_dat_i, lo_byte};
    end else begin
      rsp_o.dat = {8'h00, flash_dat_i};
    end
  end

  assign rsp_o.ack = flash_ack | page_ack_i;

  // Captured low byte is consumed by the ack on the next cycle
  a_word_ack : assert property (
    @(posedge wb_clk_i) disable iff (!rst_n_i)
    lo_take_i |=> rsp_o.ack
  ) else $error("word read without ack in its second cycle");

endmodule

//--- design/flash_subsys_top.sv
/*
 * Boot-flash Wishbone slave: decode, page register,
 * byte sequencer and result stage
 */

`timescale 1ns/1ns

module flash_subsys_top
  import flash_bus_pkg::*;
  import flash_pad_pkg::*;
#(
  // Byte-address width of the flash part
  parameter int FLASH_ADDR_W = 22
) (
  input  logic                    wb_clk_i,
  input  logic                    rst_n_i,
  input  wb_req_t                 wb_req_i,
  output wb_rsp_t                 wb_rsp_o,
  output flash_pad_t              flash_pad_o,
  input  logic [FLASH_DATA_W-1:0] flash_dat_i
);

  localparam int PAGE_W = FLASH_ADDR_W - WIN_ADR_W;

  // Decoded request to all later stages
  dec_t              dec;
  logic [PAGE_W-1:0] page;
  logic              page_ack;
  logic [15:0]       page_dat;
  // Word-read sequencing
  logic              step;
  logic              lo_take;

  flash_addr_decode u_decode (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (wb_req_i),
    .dec_o    (dec)
  );

  // Page register takes the bus write data directly
  flash_page_reg #(
    .FLASH_ADDR_W (FLASH_ADDR_W)
  ) u_page (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .dec_i    (dec),
    .wdat_i   (wb_req_i.dat),
    .page_o   (page),
    .ack_o    (page_ack),
    .rdat_o   (page_dat)
  );

  flash_byte_seq #(
    .FLASH_ADDR_W (FLASH_ADDR_W)
  ) u_seq (
    .wb_clk_i  (wb_clk_i),
    .rst_n_i   (rst_n_i),
    .dec_i     (dec),
    .page_i    (page),
    .pad_o     (flash_pad_o),
    .step_o    (step),
    .lo_take_o (lo_take)
  );

  // Flash data returns straight from the pads
  flash_read_merge u_merge (
    .wb_clk_i    (wb_clk_i),
    .rst_n_i     (rst_n_i),
    .dec_i       (dec),
    .step_i      (step),
    .lo_take_i   (lo_take),
    .flash_dat_i (flash_dat_i),
    .page_ack_i  (page_ack),
    .page_dat_i  (page_dat),
    .rsp_o       (wb_rsp_o)
  );

endmodule

//--- flash_subsys_top.f
design/flash_bus_pkg.sv
design/flash_pad_pkg.sv
design/flash_addr_decode.sv
design/flash_page_reg.sv
design/flash_byte_seq.sv
design/flash_read_merge.sv
design/flash_subsys_top.sv
verification/flash_model.sv
verification/flash_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the boot-flash testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f flash_subsys_top.f \
  --top-module flash_subsys_tb \
  -Mdir obj_dir \
  -o flash_subsys_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/flash_subsys_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

echo "Simulation completed with status 0"
exit 0

//--- verification/flash_model.sv
/*
 * Behavioral byte-wide NOR flash with asynchronous read
 * Contents follow a fixed formula of the byte address
 */

`timescale 1ns/1ns

module flash_model
  import flash_pad_pkg::*;
(
  input  flash_pad_t              pad_i,
  output logic [FLASH_DATA_W-1:0] dat_o
);

  // Cell contents from the full byte address
  function automatic logic [7:0] cell_value(input logic [21:0] a);
    logic [31:0] a32;
    logic [31:0] sum;
    a32 = {10'd0, a};
    // Low bits scatter, high bits fold in page and bank
    sum = a32 * 32'd29 + (a32 >> 11);
    return sum[7:0];
  endfunction

  // Zero-delay read while the output enable is low
  always_comb begin
    if (!pad_i.oe_n) begin
      dat_o = cell_value(pad_i.addr);
    end else begin
      // Idle data bus floats high on the board
      dat_o = 8'hff;
    end
  end

  // Program and reset pads are ignored
  // The part never leaves read-array mode

endmodule

//--- verification/flash_subsys_tb.sv
/*
 * Testbench for the boot-flash Wishbone slave: clock, reset,
 * stimulus table with directed and random entries, checks, watchdog
 */

`timescale 1ns/1ns

module flash_subsys_tb
  import flash_bus_pkg::*;
  import flash_pad_pkg::*;
;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int N_ENTRY      = 41;
  localparam int ACK_LIMIT    = 4;
  localparam int WATCHDOG_NS  = N_ENTRY * 4 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

  // One bus cycle and its expected response
  typedef struct packed {
    logic        we;
    logic [1:0]  sel;
    logic [15:0] adr;
    logic [15:0] wdat;
    logic [15:0] exp_dat;
    logic [1:0]  exp_cyc;
    logic        chk_dat;
    // Page in force when the entry runs
    logic [5:0]  page;
  } entry_t;

  logic                    wb_clk_i;
  logic                    rst_n_i;
  wb_req_t                 wb_req;
  wb_rsp_t                 wb_rsp;
  flash_pad_t              flash_pad;
  logic [FLASH_DATA_W-1:0] flash_dat;

  entry_t     table_q [N_ENTRY];
  int         n_fill;
  // Page as software sees it while the table is built
  logic [5:0] model_page;
  logic [31:0] rnd;

  flash_subsys_top #(
    .FLASH_ADDR_W (22)
  ) uut (
    .wb_clk_i    (wb_clk_i),
    .rst_n_i     (rst_n_i),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .flash_pad_o (flash_pad),
    .flash_dat_i (flash_dat)
  );

  flash_model u_flash (
    .pad_i (flash_pad),
    .dat_o (flash_dat)
  );

  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  // Expected flash byte at a byte address
  function automatic logic [7:0] flash_byte(input logic [21:0] a);
    logic [31:0] a32;
    logic [31:0] sum;
    a32 = {10'd0, a};
    sum = a32 * 32'd29 + (a32 >> 11);
    return sum[7:0];
  endfunction

  // Lane placement of a flash read
  function automatic logic [15:0] read_expect(input logic [5:0] page,
                                              input logic [15:0] adr,
                                              input logic [1:0] sel);
    logic [21:0] base;
    logic [7:0]  lo;
    logic [7:0]  hi;
    base = {page, adr[14:0], 1'b0};
    lo   = flash_byte(base);
    hi   = flash_byte(base | 22'd1);
    case (sel)
      2'b01:   return {8'h00, lo};
      2'b10:   return {hi, 8'h00};
      default: return {hi, lo};
    endcase
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s: got %h, expected %h",
               $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  task automatic add_entry(input logic we, input logic [1:0] sel, input logic [15:0] adr,
                           input logic [15:0] wdat, input logic [15:0] exp_dat,
                           input logic [1:0] exp_cyc, input logic chk_dat);
    table_q[n_fill] = '{we, sel, adr, wdat, exp_dat, exp_cyc, chk_dat, model_page};
    n_fill++;
  endtask

  // Flash window read at the current page
  task automatic add_read(input logic [1:0] sel, input logic [15:0] adr);
    add_entry(1'b0, sel, adr, 16'h0000, read_expect(model_page, adr, sel),
              (sel == 2'b11) ? 2'd2 : 2'd1, 1'b1);
  endtask

  // Page register write, low lane carries the page
  task automatic set_page(input logic [1:0] sel, input logic [15:0] wdat);
    add_entry(1'b1, sel, 16'h8000, wdat, 16'h0000, 2'd1, 1'b0);
    model_page = wdat[5:0];
  endtask

  task automatic apply_entry(input entry_t e);
    int          cycles;
    logic [31:0] exp_addr;
    @(posedge wb_clk_i);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = e.we;
    wb_req.sel = e.sel;
    wb_req.adr = e.adr;
    wb_req.dat = e.wdat;
    // Sample mid-cycle, after the combinational response settles
    cycles = 1;
    @(negedge wb_clk_i);
    while (!wb_rsp.ack && cycles < ACK_LIMIT) begin
      cycles++;
      @(negedge wb_clk_i);
    end
    check_value(32'(cycles), 32'(e.exp_cyc), "ack cycle count");
    if (e.chk_dat) begin
      check_value({16'h0, wb_rsp.dat}, {16'h0, e.exp_dat}, "read data");
    end
    if (!e.adr[15]) begin
      // Pads enabled only for a flash read
      check_value({31'h0, flash_pad.oe_n}, {31'h0, e.we}, "flash oe_n");
    end
    if (!e.adr[15] && !e.we) begin
      // Page times 64 KB plus the byte offset, odd byte at ack unless low lane only
      exp_addr = 32'(e.page) * 32'h10000 + 32'(e.adr[14:0]) * 32'd2 +
                 ((e.sel == 2'b01) ? 32'd0 : 32'd1);
      check_value({10'h0, flash_pad.addr}, exp_addr, "flash address");
    end
    check_value({31'h0, flash_pad.we_n}, 32'h1, "flash we_n");
    check_value({31'h0, flash_pad.rst_n}, 32'h1, "flash rst_n");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: testbench did not finish within %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    wb_clk_i   = 1'b0;
    rst_n_i    = 1'b0;
    wb_req     = '0;
    n_fill     = 0;
    model_page = 6'd0;
    rnd        = $urandom(32'h3d7d);

    // Byte lanes, word read, page register, flash window write
    add_read(2'b01, 16'h0010);
    add_read(2'b10, 16'h0010);
    add_read(2'b11, 16'h0010);
    add_read(2'b11, 16'h7fff);
    set_page(2'b01, 16'h0015);
    add_entry(1'b0, 2'b11, 16'h8000, 16'h0000, 16'h0015, 2'd1, 1'b1);
    add_read(2'b11, 16'h0123);
    add_read(2'b01, 16'h4000);
    add_entry(1'b1, 2'b11, 16'h0040, 16'hbeef, 16'h0000, 2'd1, 1'b0);
    add_read(2'b11, 16'h0040);
    set_page(2'b11, 16'hff3f);
    add_entry(1'b0, 2'b11, 16'h8000, 16'h0000, 16'h003f, 2'd1, 1'b1);
    add_read(2'b10, 16'h7ffe);

    // Random pages, each followed by mixed-width reads
    for (int g = 0; g < 4; g++) begin
      rnd = $urandom;
      set_page(rnd[16] ? 2'b11 : 2'b01, rnd[15:0]);
      for (int r = 0; r < 6; r++) begin
        rnd = $urandom;
        add_read(2'(rnd[31:16] % 3 + 1), {1'b0, rnd[14:0]});
      end
    end
    check_value(32'(n_fill), 32'(N_ENTRY), "stimulus table size");

    repeat (RESET_CYCLES) @(posedge wb_clk_i);
    #1;
    rst_n_i = 1'b1;

    // Idle bus after reset
    @(negedge wb_clk_i);
    check_value({31'h0, flash_pad.oe_n}, 32'h1, "idle oe_n");
    check_value({31'h0, flash_pad.we_n}, 32'h1, "idle we_n");
    check_value({31'h0, flash_pad.rst_n}, 32'h1, "idle rst_n");
    check_value({31'h0, wb_rsp.ack}, 32'h0, "idle ack");

    // Back-to-back cycles, next request right after each ack
    for (int i = 0; i < N_ENTRY; i++) begin
      apply_entry(table_q[i]);
    end

    @(posedge wb_clk_i);
    #1;
    wb_req = '0;
    @(negedge wb_clk_i);
    check_value({31'h0, wb_rsp.ack}, 32'h0, "ack after last cycle");

    $display(">>> PASS");
    $finish;
  end

endmodule
